// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing -j 0
TOP       = issue_top_tb
FILELIST  = issue_top.f
BUILD_DIR = obj_dir
LOG       = sim.log
SOURCES   = $(wildcard design/*.sv) $(wildcard testbench/*.sv) $(wildcard testbench/*.svh)

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Verification passed$$" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== design/fetch_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_queue (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    fetch_valid,
  input  logic                    flush,
  input  queue_pkg::pc_t          fetch_pc,
  input  logic [63:0]             fetch_data,
  input  queue_pkg::issue_count_t issue_count,
  output isa_pkg::instr_t         head_instr0,
  output isa_pkg::instr_t         head_instr1,
  output logic                    head_valid0,
  output logic                    head_valid1,
  output queue_pkg::pc_t          issue_pc0,
  output queue_pkg::pc_t          issue_pc1,
  output isa_pkg::instr_t         issue_instr0,
  output isa_pkg::instr_t         issue_instr1,
  output logic                    fetch_stall
);
  import isa_pkg::*;
  import queue_pkg::*;

  pc_t    pc_mem [queue_depth];
  instr_t instr_mem [queue_depth];
  pc_t    pc_next [queue_depth];
  instr_t instr_next [queue_depth];

  logic [ptr_width-1:0] wr_ptr;
  logic [ptr_width-1:0] wr_ptr1;
  logic [ptr_width-1:0] wr_ptr_next;
  logic [ptr_width-1:0] rd_ptr;
  logic [ptr_width-1:0] rd_ptr_next;
  logic [ptr_width-1:0] rd_base;
  logic [ptr_width-1:0] rd_base1;

  logic [count_width-1:0] count;
  logic [count_width-1:0] fill;
  logic [count_width-1:0] count_next;

  pc_t head_pc0;
  pc_t head_pc1;

  assign wr_ptr1 = wr_ptr + ptr_width'(1);

  // Push side, with flush taking priority over a strobe in the same cycle
  always_comb begin
    pc_next = pc_mem;
    instr_next = instr_mem;
    wr_ptr_next = wr_ptr;
    rd_base = rd_ptr;
    fill = count;
    if (flush) begin
      wr_ptr_next = '0;
      rd_base = '0;
      fill = '0;
    end else if (fetch_valid) begin
      pc_next[wr_ptr] = fetch_pc;
      instr_next[wr_ptr] = fetch_data[31:0];
      pc_next[wr_ptr1] = fetch_pc + pc_t'(4);
      instr_next[wr_ptr1] = fetch_data[63:32];
      wr_ptr_next = wr_ptr + ptr_width'(2);
      fill = count + count_width'(2);
    end
  end

  // Heads read the post-push view, so a fresh pair can issue at once
  assign rd_base1 = rd_base + ptr_width'(1);
  assign head_valid0 = fill != '0;
  assign head_valid1 = fill > count_width'(1);
  assign head_instr0 = head_valid0 ? instr_next[rd_base] : nop_instr;
  assign head_instr1 = head_valid1 ? instr_next[rd_base1] : nop_instr;
  assign head_pc0 = head_valid0 ? pc_next[rd_base] : '0;
  assign head_pc1 = head_valid1 ? pc_next[rd_base1] : '0;

  // Pop side; issue_count never exceeds the valid heads
  assign count_next = fill - count_width'(issue_count);
  assign rd_ptr_next = rd_base + ptr_width'(issue_count);
  assign fetch_stall = count_next > count_width'(stall_level);

  assign issue_pc0 = (issue_count > 2'd0) ? head_pc0 : '0;
  assign issue_pc1 = (issue_count > 2'd1) ? head_pc1 : '0;
  assign issue_instr0 = (issue_count > 2'd0) ? head_instr0 : nop_instr;
  assign issue_instr1 = (issue_count > 2'd1) ? head_instr1 : nop_instr;

  always_ff @(posedge clock) begin
    pc_mem <= pc_next;
    instr_mem <= instr_next;
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      count <= '0;
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      count <= count_next;
      wr_ptr <= wr_ptr_next;
      rd_ptr <= rd_ptr_next;
    end
  end

endmodule

`default_nettype wire

// ==== design/instr_class.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_class (
  input  isa_pkg::instr_t    instr,
  output logic               basic,
  output logic               complex,
  output logic               wren,
  output logic               rden1,
  output logic               rden2,
  output isa_pkg::reg_addr_t waddr,
  output isa_pkg::reg_addr_t raddr1,
  output isa_pkg::reg_addr_t raddr2
);
  import isa_pkg::*;

  logic writes;  // Opcode has an integer destination

  assign waddr = instr.r_form.rd;
  assign raddr1 = instr.r_form.rs1;
  assign raddr2 = instr.r_form.rs2;

  always_comb begin
    basic = 1'b0;
    writes = 1'b0;
    rden1 = 1'b0;
    rden2 = 1'b0;
    case (instr.r_form.opcode)
      opcode_lui, opcode_auipc, opcode_jal: begin
        writes = 1'b1;
      end
      opcode_jalr, opcode_load: begin
        writes = 1'b1;
        rden1 = 1'b1;
      end
      opcode_branch, opcode_store: begin
        rden1 = 1'b1;
        rden2 = 1'b1;
      end
      opcode_immediate: begin
        writes = 1'b1;
        rden1 = 1'b1;
        case (instr.i_form.funct3)
          funct_add, funct_slt, funct_sltu, funct_xor, funct_or, funct_and: begin
            basic = 1'b1;
          end
          // Shift amount sits low in the immediate, upper bits act as funct7
          funct_sll: begin
            basic = instr.i_form.imm[11:5] == funct7_base;
          end
          funct_srl: begin
            basic = (instr.i_form.imm[11:5] == funct7_base) ||
                    (instr.i_form.imm[11:5] == funct7_alt);
          end
          default: begin
            basic = 1'b0;
          end
        endcase
      end
      opcode_register: begin
        writes = 1'b1;
        rden1 = 1'b1;
        rden2 = 1'b1;
        case (instr.r_form.funct7)
          funct7_base: begin
            basic = 1'b1;
          end
          funct7_alt: begin  // sub and sra only
            basic = (instr.r_form.funct3 == funct_add) ||
                    (instr.r_form.funct3 == funct_srl);
          end
          default: begin
            basic = 1'b0;  // M extension and reserved
          end
        endcase
      end
      opcode_system: begin
        case (instr.r_form.funct3)
          3'd1, 3'd2, 3'd3: begin  // CSR with register source
            writes = 1'b1;
            rden1 = 1'b1;
          end
          3'd5, 3'd6, 3'd7: begin  // CSR immediate forms
            writes = 1'b1;
          end
          default: begin
            writes = 1'b0;
          end
        endcase
      end
      default: begin
        writes = 1'b0;
      end
    endcase
  end

  // Anything not a plain ALU op, unknown opcodes included, goes alone
  assign complex = ~basic;
  assign wren = writes && (instr.r_form.rd != '0);

endmodule

`default_nettype wire

// ==== design/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

  // RV32I major opcodes
  localparam logic [6:0] opcode_lui       = 7'b0110111;
  localparam logic [6:0] opcode_auipc     = 7'b0010111;
  localparam logic [6:0] opcode_jal       = 7'b1101111;
  localparam logic [6:0] opcode_jalr      = 7'b1100111;
  localparam logic [6:0] opcode_branch    = 7'b1100011;
  localparam logic [6:0] opcode_load      = 7'b0000011;
  localparam logic [6:0] opcode_store     = 7'b0100011;
  localparam logic [6:0] opcode_immediate = 7'b0010011;
  localparam logic [6:0] opcode_register  = 7'b0110011;
  localparam logic [6:0] opcode_system    = 7'b1110011;

  // funct3 of the integer ALU group
  localparam logic [2:0] funct_add  = 3'b000;
  localparam logic [2:0] funct_sll  = 3'b001;
  localparam logic [2:0] funct_slt  = 3'b010;
  localparam logic [2:0] funct_sltu = 3'b011;
  localparam logic [2:0] funct_xor  = 3'b100;
  localparam logic [2:0] funct_srl  = 3'b101;
  localparam logic [2:0] funct_or   = 3'b110;
  localparam logic [2:0] funct_and  = 3'b111;

  localparam logic [6:0] funct7_base = 7'b0000000;
  localparam logic [6:0] funct7_alt  = 7'b0100000;  // sub, sra, srai

  typedef logic [4:0] reg_addr_t;

  // Register and immediate views of one instruction word
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      reg_addr_t  rs2;
      reg_addr_t  rs1;
      logic [2:0] funct3;
      reg_addr_t  rd;
      logic [6:0] opcode;
    } r_form;
    struct packed {
      logic [11:0] imm;
      reg_addr_t   rs1;
      logic [2:0]  funct3;
      reg_addr_t   rd;
      logic [6:0]  opcode;
    } i_form;
  } instr_t;

  // addi x0,x0,0
  localparam instr_t nop_instr = 32'h00000013;

endpackage

`default_nettype wire

// ==== design/issue_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module issue_top (
  input  logic            clock,
  input  logic            reset,
  input  logic            fetch_valid,
  input  logic            flush,
  input  logic            hold,
  input  queue_pkg::pc_t  fetch_pc,
  input  logic [63:0]     fetch_data,
  output queue_pkg::pc_t  issue_pc0,
  output isa_pkg::instr_t issue_instr0,
  output queue_pkg::pc_t  issue_pc1,
  output isa_pkg::instr_t issue_instr1,
  output logic            fetch_stall
);
  import isa_pkg::*;
  import queue_pkg::*;

  instr_t       head_instr0;
  instr_t       head_instr1;
  logic         head_valid0;
  logic         head_valid1;
  issue_count_t issue_count;

  // Older slot supplies the destination, younger slot the class and sources
  logic      wren0;
  reg_addr_t waddr0;
  logic      basic1;
  logic      rden1_1;
  logic      rden2_1;
  reg_addr_t raddr1_1;
  reg_addr_t raddr2_1;

  fetch_queue i_fetch_queue (
    .clock        (clock),
    .reset        (reset),
    .fetch_valid  (fetch_valid),
    .flush        (flush),
    .fetch_pc     (fetch_pc),
    .fetch_data   (fetch_data),
    .issue_count  (issue_count),
    .head_instr0  (head_instr0),
    .head_instr1  (head_instr1),
    .head_valid0  (head_valid0),
    .head_valid1  (head_valid1),
    .issue_pc0    (issue_pc0),
    .issue_pc1    (issue_pc1),
    .issue_instr0 (issue_instr0),
    .issue_instr1 (issue_instr1),
    .fetch_stall  (fetch_stall)
  );

  instr_class class0 (
    .instr   (head_instr0),
    .basic   (),
    .complex (),
    .wren    (wren0),
    .rden1   (),
    .rden2   (),
    .waddr   (waddr0),
    .raddr1  (),
    .raddr2  ()
  );

  instr_class class1 (
    .instr   (head_instr1),
    .basic   (basic1),
    .complex (),
    .wren    (),
    .rden1   (rden1_1),
    .rden2   (rden2_1),
    .waddr   (),
    .raddr1  (raddr1_1),
    .raddr2  (raddr2_1)
  );

  pair_arbiter i_pair_arbiter (
    .basic1      (basic1),
    .wren0       (wren0),
    .rden1_1     (rden1_1),
    .rden2_1     (rden2_1),
    .waddr0      (waddr0),
    .raddr1_1    (raddr1_1),
    .raddr2_1    (raddr2_1),
    .head_valid0 (head_valid0),
    .head_valid1 (head_valid1),
    .hold        (hold),
    .issue_count (issue_count)
  );

endmodule

`default_nettype wire

// ==== design/pair_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module pair_arbiter (
  input  logic                    basic1,
  input  logic                    wren0,
  input  logic                    rden1_1,
  input  logic                    rden2_1,
  input  isa_pkg::reg_addr_t      waddr0,
  input  isa_pkg::reg_addr_t      raddr1_1,
  input  isa_pkg::reg_addr_t      raddr2_1,
  input  logic                    head_valid0,
  input  logic                    head_valid1,
  input  logic                    hold,
  output queue_pkg::issue_count_t issue_count
);
  import queue_pkg::*;

  logic         hazard;
  issue_count_t pass;

  // Younger reads what the older one writes; x0 never sets wren0
  assign hazard = wren0 && ((rden1_1 && (raddr1_1 == waddr0)) ||
                            (rden2_1 && (raddr2_1 == waddr0)));

  always_comb begin
    if (basic1 && !hazard) begin
      pass = 2'd2;
    end else begin
      pass = 2'd1;
    end
    if (hold) begin
      pass = 2'd0;
    end
    if (!head_valid0) begin
      pass = 2'd0;
    end else if (!head_valid1 && pass == 2'd2) begin
      pass = 2'd1;  // Only one entry waiting
    end
  end

  assign issue_count = pass;

endmodule

`default_nettype wire

// ==== design/queue_pkg.sv ====
`default_nettype none

package queue_pkg;

  localparam int queue_depth = 8;
  localparam int ptr_width   = 3;
  localparam int count_width = 4;  // Holds a full count of 8

  // Stall once more than this many entries remain
  localparam int stall_level = 4;

  typedef logic [31:0] pc_t;

  typedef logic [1:0] issue_count_t;  // 0, 1 or 2

endpackage

`default_nettype wire

// ==== issue_top.f ====
+incdir+testbench
design/isa_pkg.sv
design/queue_pkg.sv
design/instr_class.sv
design/pair_arbiter.sv
design/fetch_queue.sv
design/issue_top.sv
testbench/issue_top_tb.sv

// ==== testbench/issue_model.svh ====
`ifndef ISSUE_MODEL_SVH
`define ISSUE_MODEL_SVH

// Queue contents, oldest entry first
pc_t    model_pc [$];
instr_t model_instr [$];

pc_t    exp_pc0;
pc_t    exp_pc1;
instr_t exp_instr0;
instr_t exp_instr1;
logic   exp_stall;
int     exp_count;

// Plain integer ALU operation with a legal upper field
function automatic bit alu_basic(input instr_t w);
  logic [6:0] upper;
  logic [2:0] f3;
  upper = w.r_form.funct7;
  f3 = w.r_form.funct3;
  if (w.r_form.opcode == opcode_immediate) begin
    if (f3 == funct_sll) return upper == funct7_base;
    if (f3 == funct_srl) return (upper == funct7_base) || (upper == funct7_alt);
    return 1'b1;
  end
  if (w.r_form.opcode == opcode_register) begin
    if (upper == funct7_base) return 1'b1;
    return (upper == funct7_alt) && ((f3 == funct_add) || (f3 == funct_srl));
  end
  return 1'b0;
endfunction

// Register written, x0 when none
function automatic reg_addr_t dest_reg(input instr_t w);
  case (w.r_form.opcode)
    opcode_lui, opcode_auipc, opcode_jal, opcode_jalr, opcode_load,
    opcode_immediate, opcode_register: return w.r_form.rd;
    opcode_system: return (w.r_form.funct3 inside {3'd1, 3'd2, 3'd3, 3'd5, 3'd6, 3'd7}) ?
                          w.r_form.rd : 5'd0;
    default: return 5'd0;
  endcase
endfunction

function automatic bit raw_hazard(input instr_t older, input instr_t younger);
  reg_addr_t rd;
  bit        uses_rs1;
  bit        uses_rs2;
  rd = dest_reg(older);
  uses_rs1 = younger.r_form.opcode inside {opcode_jalr, opcode_load, opcode_branch,
      opcode_store, opcode_immediate, opcode_register} ||
      (younger.r_form.opcode == opcode_system && younger.r_form.funct3 inside {[3'd1:3'd3]});
  uses_rs2 = younger.r_form.opcode inside {opcode_branch, opcode_store, opcode_register};
  return (rd != 5'd0) && ((uses_rs1 && younger.r_form.rs1 == rd) ||
                          (uses_rs2 && younger.r_form.rs2 == rd));
endfunction

// One cycle of the queue: push or flush, then issue, then the stall level
task automatic predict_cycle(input logic fv, input logic fl, input logic hd,
                             input pc_t pc, input logic [63:0] data);
  exp_pc0 = '0;
  exp_pc1 = '0;
  exp_instr0 = nop_instr;
  exp_instr1 = nop_instr;
  if (fl) begin
    model_pc.delete();
    model_instr.delete();
  end else if (fv) begin
    model_pc.push_back(pc);
    model_instr.push_back(instr_t'(data[31:0]));
    model_pc.push_back(pc + pc_t'(4));
    model_instr.push_back(instr_t'(data[63:32]));
  end
  exp_count = (hd || model_pc.size() == 0) ? 0 : 1;
  if (exp_count == 1 && model_pc.size() > 1 && alu_basic(model_instr[1]) &&
      !raw_hazard(model_instr[0], model_instr[1])) exp_count = 2;
  if (exp_count > 0) begin
    exp_pc0 = model_pc.pop_front();
    exp_instr0 = model_instr.pop_front();
  end
  if (exp_count > 1) begin
    exp_pc1 = model_pc.pop_front();
    exp_instr1 = model_instr.pop_front();
  end
  exp_stall = model_pc.size() > stall_level;
endtask

`endif

// ==== testbench/issue_top_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module issue_top_tb;
  import isa_pkg::*;
  import queue_pkg::*;

  localparam int period = 100;
  localparam int random_cycles = 500;
  localparam int cycle_budget = 40 + 3 * random_cycles;

  logic        clock;
  logic        reset;
  logic        fetch_valid;
  logic        flush;
  logic        hold;
  pc_t         fetch_pc;
  logic [63:0] fetch_data;
  pc_t         issue_pc0;
  pc_t         issue_pc1;
  instr_t      issue_instr0;
  instr_t      issue_instr1;
  logic        fetch_stall;

  int   test_errors;
  int   total_errors;
  int   tests_run;
  int   tests_bad;
  pc_t  next_pc;
  pc_t  last_pc;
  logic order_known;
  logic last_stall;

  `include "issue_model.svh"

  issue_top i_issue_top (
    .clock        (clock),
    .reset        (reset),
    .fetch_valid  (fetch_valid),
    .flush        (flush),
    .hold         (hold),
    .fetch_pc     (fetch_pc),
    .fetch_data   (fetch_data),
    .issue_pc0    (issue_pc0),
    .issue_instr0 (issue_instr0),
    .issue_pc1    (issue_pc1),
    .issue_instr1 (issue_instr1),
    .fetch_stall  (fetch_stall)
  );

  always #(period / 2) clock = ~clock;

  task automatic check_pc(input string name, input pc_t actual, input pc_t expected);
    if (actual !== expected) begin
      $display("** Error at %0t ns: %s = %h, expected %h", $time, name, actual, expected);
      test_errors++;
    end
  endtask

  task automatic check_instr(input string name, input instr_t actual, input instr_t expected);
    if (actual !== expected) begin
      $display("** Error at %0t ns: %s = %h, expected %h", $time, name, actual, expected);
      test_errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      $display("** Error at %0t ns: %s = %b, expected %b", $time, name, actual, expected);
      test_errors++;
    end
  endtask

  function automatic instr_t encode_instr(input logic [6:0] f7, input reg_addr_t rs2,
      input reg_addr_t rs1, input logic [2:0] f3, input reg_addr_t rd, input logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  // Mostly ALU work on x0 to x3, so hazards and x0 destinations are common
  function automatic instr_t random_instr();
    instr_t     w;
    logic [6:0] others [5];
    others = '{opcode_jal, opcode_jalr, opcode_auipc, opcode_system, 7'b1111111};
    w = encode_instr(funct7_base, reg_addr_t'($urandom_range(0, 3)),
        reg_addr_t'($urandom_range(0, 3)), 3'($urandom_range(0, 7)),
        reg_addr_t'($urandom_range(0, 3)), opcode_immediate);
    case ($urandom_range(0, 5))
      0: w.r_form.funct7 = funct7_alt;
      1: w.r_form.funct7 = 7'h01;  // M extension
      default: w.r_form.funct7 = funct7_base;
    endcase
    case ($urandom_range(0, 9))
      0, 1, 2: w.r_form.opcode = opcode_immediate;
      3, 4: w.r_form.opcode = opcode_register;
      5: w.r_form.opcode = opcode_lui;
      6: w.r_form.opcode = opcode_load;
      7: w.r_form.opcode = opcode_store;
      8: w.r_form.opcode = opcode_branch;
      default: w.r_form.opcode = others[$urandom_range(0, 4)];
    endcase
    return w;
  endfunction

  // Older addi x4,x0,7 in the low word, younger add x3,x1,x2 above it
  function automatic logic [63:0] basic_pair();
    return {encode_instr(funct7_base, 5'd2, 5'd1, funct_add, 5'd3, opcode_register),
            encode_instr(funct7_base, 5'd7, 5'd0, funct_add, 5'd4, opcode_immediate)};
  endfunction

  task automatic run_cycle(input logic fv, input logic fl, input logic hd,
                           input logic [63:0] data);
    logic strobe;
    strobe = fv && !last_stall;  // Upstream never strobes into a stall
    @(negedge clock);
    fetch_valid = strobe;
    flush = fl;
    hold = hd;
    fetch_pc = next_pc;
    fetch_data = data;
    predict_cycle(strobe, fl, hd, next_pc, data);
    if (strobe) next_pc = next_pc + pc_t'(8);
    if (fl) order_known = 1'b0;
    #10;
    check_pc("issue_pc0", issue_pc0, exp_pc0);
    check_instr("issue_instr0", issue_instr0, exp_instr0);
    check_pc("issue_pc1", issue_pc1, exp_pc1);
    check_instr("issue_instr1", issue_instr1, exp_instr1);
    check_flag("fetch_stall", fetch_stall, exp_stall);
    // Issued pcs run one word apart in program order
    if (exp_count > 0) begin
      if (order_known) begin
        check_pc("issue_pc0 order", issue_pc0, last_pc + pc_t'(4));
        last_pc = last_pc + pc_t'(4);
      end else begin
        last_pc = exp_pc0;
      end
      order_known = 1'b1;
    end
    if (exp_count > 1) begin
      check_pc("issue_pc1 order", issue_pc1, last_pc + pc_t'(4));
      last_pc = last_pc + pc_t'(4);
    end
    last_stall = exp_stall;
  endtask

  task automatic expect_issued(input int n);
    check_flag("slot 0 issued", issue_pc0 != 0, n > 0);
    check_flag("slot 1 issued", issue_pc1 != 0, n > 1);
  endtask

  task automatic drain_queue();
    while (model_pc.size() > 0) run_cycle(1'b0, 1'b0, 1'b0, '0);
  endtask

  task automatic drive_random(input int cycles, input int fetch_w, input int hold_w,
                              input int flush_w);
    repeat (cycles) begin
      run_cycle($urandom_range(0, 99) < fetch_w, $urandom_range(0, 99) < flush_w,
                $urandom_range(0, 99) < hold_w, {random_instr(), random_instr()});
    end
  endtask

  task automatic report_test(input string name);
    $display("%s: %0d errors", name, test_errors);
    tests_run++;
    if (test_errors != 0) tests_bad++;
    total_errors += test_errors;
    test_errors = 0;
  endtask

  initial begin
    #(cycle_budget * period + 20 * period);
    $display("Timeout: run did not finish within %0d cycles", cycle_budget + 20);
    $display("Verification failed");
    $finish;
  end

  initial begin
    clock = 1'b0;
    reset = 1'b0;
    fetch_valid = 1'b0;
    flush = 1'b0;
    hold = 1'b0;
    fetch_pc = '0;
    fetch_data = '0;
    test_errors = 0;
    total_errors = 0;
    tests_run = 0;
    tests_bad = 0;
    next_pc = 32'h0000_1000;
    last_pc = '0;
    order_known = 1'b0;
    last_stall = 1'b0;
    void'($urandom(32'h7a05));
    repeat (3) @(negedge clock);
    reset = 1'b1;

    run_cycle(1'b0, 1'b0, 1'b0, '0);
    expect_issued(0);
    report_test("after reset");

    run_cycle(1'b1, 1'b0, 1'b0, basic_pair());
    expect_issued(2);
    run_cycle(1'b1, 1'b0, 1'b0,
              {encode_instr(7'h00, 5'd0, 5'd6, 3'd2, 5'd5, opcode_load),
               encode_instr(funct7_base, 5'd7, 5'd0, funct_add, 5'd4, opcode_immediate)});
    expect_issued(1);
    run_cycle(1'b0, 1'b0, 1'b0, '0);
    expect_issued(1);
    report_test("pairing");

    // Younger reads x5 through rs1, then through rs2, then rd x0 clears the hazard
    run_cycle(1'b1, 1'b0, 1'b0,
              {encode_instr(funct7_base, 5'd1, 5'd5, funct_add, 5'd6, opcode_register),
               encode_instr(funct7_base, 5'd1, 5'd0, funct_add, 5'd5, opcode_immediate)});
    expect_issued(1);
    drain_queue();
    run_cycle(1'b1, 1'b0, 1'b0,
              {encode_instr(funct7_base, 5'd5, 5'd1, funct_xor, 5'd6, opcode_register),
               encode_instr(funct7_base, 5'd1, 5'd0, funct_or, 5'd5, opcode_immediate)});
    expect_issued(1);
    drain_queue();
    run_cycle(1'b1, 1'b0, 1'b0,
              {encode_instr(funct7_base, 5'd0, 5'd0, funct_add, 5'd6, opcode_register),
               encode_instr(funct7_base, 5'd1, 5'd0, funct_add, 5'd0, opcode_immediate)});
    expect_issued(2);
    report_test("read-after-write hazard");

    drive_random(random_cycles, 50, 0, 0);
    drain_queue();
    report_test("ordering");

    run_cycle(1'b1, 1'b0, 1'b1, basic_pair());
    expect_issued(0);
    run_cycle(1'b0, 1'b0, 1'b0, '0);
    expect_issued(2);
    drive_random(random_cycles, 75, 35, 0);
    drain_queue();
    report_test("hold and stall");

    run_cycle(1'b1, 1'b0, 1'b1, basic_pair());
    run_cycle(1'b1, 1'b1, 1'b0, basic_pair());
    expect_issued(0);
    run_cycle(1'b0, 1'b0, 1'b0, '0);
    expect_issued(0);
    run_cycle(1'b1, 1'b0, 1'b0, basic_pair());
    expect_issued(2);
    drive_random(random_cycles, 60, 6, 3);
    report_test("flush");

    $display("%0d tests, %0d with errors, %0d errors in total", tests_run, tests_bad,
             total_errors);
    if (total_errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
